/* hw/coord_pkg.sv */
package coord_pkg;

    // Largest NUM_MODULES the message and peer formats support
    localparam int max_modules = 4;

    // =========================================================================
    // Link and power encodings
    // =========================================================================

    typedef enum logic [3:0] {
        LINK_RESET    = 4'h0,
        LINK_TRAINING = 4'h1,
        LINK_ACTIVE   = 4'h2,
        LINK_RETRAIN  = 4'h3,
        LINK_ERROR    = 4'hF
    } link_state_e;

    // Higher value means deeper power saving
    typedef enum logic [1:0] {
        PWR_L0 = 2'd0,
        PWR_L1 = 2'd1,
        PWR_L2 = 2'd2,
        PWR_L3 = 2'd3
    } power_state_e;

    // =========================================================================
    // Coordination messages
    // =========================================================================

    typedef enum logic [3:0] {
        MSG_DISCOVERY = 4'h0,
        MSG_STATUS    = 4'h1,
        MSG_POWER_REQ = 4'h2,
        MSG_POWER_ACK = 4'h3
    } msg_type_e;

    // Payload of DISCOVERY and STATUS
    typedef struct packed {
        logic [1:0]   spare;
        logic [7:0]   active_lanes;
        power_state_e power;
        link_state_e  link;
    } status_payload_t;

    // Payload of POWER_REQ and POWER_ACK
    typedef struct packed {
        logic [13:0]  spare;
        power_state_e pwr;
    } power_payload_t;

    typedef union packed {
        status_payload_t status;
        power_payload_t  power;
    } coord_payload_u;

    typedef struct packed {
        msg_type_e      msg_type;
        logic [3:0]     source_id;
        logic [7:0]     seq_num;
        coord_payload_u payload;
    } coord_msg_t;

    // Encodings kept from the original coordinator
    typedef enum logic [3:0] {
        COORD_RESET       = 4'h0,
        COORD_DISCOVERY   = 4'h1,
        COORD_NEGOTIATION = 4'h2,
        COORD_ACTIVE      = 4'h4,
        COORD_POWER_SYNC  = 4'h5,
        COORD_ERROR       = 4'hF
    } coord_state_e;

    // What this die knows about one peer
    typedef struct packed {
        logic         discovered;
        logic         ready;
        link_state_e  link;
        power_state_e power;
        logic [7:0]   lanes;
    } peer_rec_t;

endpackage

/* hw/coord_msg_decode.sv */
module coord_msg_decode #(
    parameter int NUM_MODULES = 4,
    parameter int MODULE_ID   = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic [NUM_MODULES-1:0]  coord_valid_in,
    input  coord_pkg::coord_msg_t   coord_data_in [NUM_MODULES],

    output coord_pkg::peer_rec_t    peers [NUM_MODULES],
    output logic [NUM_MODULES-1:0]  peer_pwr_req,
    output coord_pkg::power_state_e peer_pwr_val [NUM_MODULES]
);

    import coord_pkg::*;

    // =========================================================================
    // Peer records
    // =========================================================================

    // No back-pressure, every valid slot is consumed on the cycle it shows up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            peers        <= '{default: '0};
            peer_pwr_req <= '0;
        end else begin
            peer_pwr_req <= '0;
            for (int i = 0; i < NUM_MODULES; i++) begin
                // Own slot carries our own traffic looped back
                if (i != MODULE_ID && coord_valid_in[i]) begin
                    case (coord_data_in[i].msg_type)
                        MSG_DISCOVERY: begin
                            peers[i].discovered <= 1'b1;
                            peers[i].lanes <=
                                coord_data_in[i].payload.status.active_lanes;
                        end

                        MSG_STATUS: begin
                            peers[i].link  <= coord_data_in[i].payload.status.link;
                            peers[i].power <= coord_data_in[i].payload.status.power;
                            peers[i].lanes <=
                                coord_data_in[i].payload.status.active_lanes;
                            peers[i].ready <=
                                (coord_data_in[i].payload.status.link == LINK_ACTIVE);
                        end

                        MSG_POWER_REQ: begin
                            peer_pwr_req[i] <= 1'b1;
                        end

                        default: begin
                            // POWER_ACK is only meaningful to followers of a
                            // remote coordinator and carries nothing to keep
                        end
                    endcase
                end
            end
        end
    end

    // Requested level, qualified by peer_pwr_req
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_MODULES; i++) begin
            if (coord_valid_in[i] && coord_data_in[i].msg_type == MSG_POWER_REQ) begin
                peer_pwr_val[i] <= coord_data_in[i].payload.power.pwr;
            end
        end
    end

endmodule

/* hw/coord_sequencer.sv */
module coord_sequencer #(
    parameter int NUM_MODULES   = 4,
    parameter int MODULE_ID     = 0,
    parameter int COORD_TIMEOUT = 1000
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  coord_pkg::peer_rec_t    peers [NUM_MODULES],
    input  logic [7:0]              active_lanes,
    input  logic                    pwr_pending,

    output coord_pkg::coord_state_e state,
    output logic                    is_coordinator
);

    import coord_pkg::*;

    localparam int TW = $clog2(COORD_TIMEOUT + 1);
    localparam int IW = $clog2(max_modules);

    coord_state_e    state_next;
    logic [TW-1:0]   phase_timer;
    logic            timed_out;
    logic            any_discovered;
    logic            all_ready;
    logic [IW-1:0]   coord_id;
    logic [IW-1:0]   best_id;
    logic [7:0]      best_lanes;

    // =========================================================================
    // Peer summary and election
    // =========================================================================

    // Most lanes wins, equal lanes go to the lower slot
    always_comb begin
        any_discovered = 1'b0;
        all_ready      = 1'b1;
        best_id        = IW'(MODULE_ID);
        best_lanes     = active_lanes;
        for (int i = 0; i < NUM_MODULES; i++) begin
            if (i != MODULE_ID && peers[i].discovered) begin
                any_discovered = 1'b1;
                if (!peers[i].ready) begin
                    all_ready = 1'b0;
                end
                if (peers[i].lanes > best_lanes ||
                    (peers[i].lanes == best_lanes && IW'(i) < best_id)) begin
                    best_id    = IW'(i);
                    best_lanes = peers[i].lanes;
                end
            end
        end
    end

    // Role is fixed for the whole negotiation round
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_coordinator <= 1'b0;
            coord_id       <= '0;
        end else if (state == COORD_DISCOVERY && state_next == COORD_NEGOTIATION) begin
            is_coordinator <= (best_id == IW'(MODULE_ID));
            coord_id       <= best_id;
        end
    end

    // =========================================================================
    // Coordination FSM
    // =========================================================================

    assign timed_out = (phase_timer == TW'(COORD_TIMEOUT));

    always_comb begin
        state_next = state;
        case (state)
            COORD_RESET:       state_next = COORD_DISCOVERY;
            COORD_DISCOVERY: begin
                if (any_discovered)  state_next = COORD_NEGOTIATION;
                else if (timed_out)  state_next = COORD_ERROR;
            end
            COORD_NEGOTIATION: begin
                if (is_coordinator ? all_ready : peers[coord_id].ready) begin
                    state_next = COORD_ACTIVE;
                end else if (timed_out) begin
                    state_next = COORD_ERROR;
                end
            end
            COORD_ACTIVE:      if (pwr_pending) state_next = COORD_POWER_SYNC;
            // Single cycle, the vote completes here
            COORD_POWER_SYNC:  state_next = COORD_ACTIVE;
            COORD_ERROR:       if (timed_out) state_next = COORD_DISCOVERY;
            default:           state_next = COORD_ERROR;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= COORD_RESET;
            phase_timer <= '0;
        end else begin
            state <= state_next;
            // Restart on every transition, saturate at the limit
            if (state_next != state) phase_timer <= '0;
            else if (!timed_out)     phase_timer <= phase_timer + 1'b1;
        end
    end

endmodule

/* hw/power_consensus.sv */
module power_consensus #(
    parameter int NUM_MODULES = 4,
    parameter int MODULE_ID   = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  coord_pkg::coord_state_e state,
    input  coord_pkg::peer_rec_t    peers [NUM_MODULES],
    input  logic [NUM_MODULES-1:0]  peer_pwr_req,
    input  coord_pkg::power_state_e peer_pwr_val [NUM_MODULES],
    input  coord_pkg::power_state_e power_state,
    input  coord_pkg::power_state_e power_sync_req,

    output logic                    pwr_pending,
    output coord_pkg::power_state_e coordinated_power_state
);

    import coord_pkg::*;

    power_state_e req_q [NUM_MODULES];
    power_state_e local_last;
    logic         local_seen;
    logic         local_new;
    logic [2:0]   cnt [4];
    logic [2:0]   n_voters;
    logic         found;
    power_state_e vote;

    // A local request counts once and re-arms when it changes
    assign local_new = (power_sync_req != power_state) &&
                       !(local_seen && power_sync_req == local_last);

    always_comb begin
        cnt      = '{default: '0};
        cnt[power_sync_req] = 3'd1;
        n_voters = 3'd1;
        found    = 1'b0;
        vote     = PWR_L0;
        for (int i = 0; i < NUM_MODULES; i++) begin
            if (i != MODULE_ID && peers[i].discovered) begin
                cnt[req_q[i]] = cnt[req_q[i]] + 3'd1;
                n_voters      = n_voters + 3'd1;
            end
        end
        // Deepest level holding half the votes or more, ties go restrictive
        for (int lvl = 3; lvl > 0; lvl--) begin
            if (!found && (4'(cnt[lvl]) << 1) >= 4'(n_voters)) begin
                vote  = power_state_e'(2'(lvl));
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q                   <= '{default: PWR_L0};
            pwr_pending             <= 1'b0;
            local_seen              <= 1'b0;
            local_last              <= PWR_L0;
            coordinated_power_state <= PWR_L0;
        end else begin
            for (int i = 0; i < NUM_MODULES; i++) begin
                if (peer_pwr_req[i]) req_q[i] <= peer_pwr_val[i];
            end
            if (state == COORD_POWER_SYNC) begin
                // Late peer requests start the next round
                pwr_pending             <= |peer_pwr_req;
                local_seen              <= 1'b1;
                local_last              <= power_sync_req;
                coordinated_power_state <= vote;
            end else if (local_new || |peer_pwr_req) begin
                pwr_pending <= 1'b1;
            end
        end
    end

endmodule

/* hw/coord_msg_encode.sv */
module coord_msg_encode #(
    parameter int MODULE_ID = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  coord_pkg::coord_state_e state,
    input  logic                    is_coordinator,
    input  logic [7:0]              active_lanes,
    input  coord_pkg::power_state_e power_state,
    input  coord_pkg::link_state_e  link_state,
    input  coord_pkg::power_state_e consensus,

    input  logic                    coord_ready,
    output logic                    coord_valid,
    output coord_pkg::coord_msg_t   coord_data
);

    import coord_pkg::*;

    coord_msg_t next_msg;
    logic       load;
    logic [7:0] seq_q;

    // Message that would go out this cycle
    always_comb begin
        next_msg           = '0;
        next_msg.source_id = 4'(MODULE_ID);
        next_msg.seq_num   = seq_q;
        load               = 1'b0;
        case (state)
            COORD_DISCOVERY: begin
                load                                 = 1'b1;
                next_msg.msg_type                    = MSG_DISCOVERY;
                next_msg.payload.status.active_lanes = active_lanes;
            end
            COORD_ACTIVE: begin
                load                                 = 1'b1;
                next_msg.msg_type                    = MSG_STATUS;
                next_msg.payload.status.active_lanes = active_lanes;
                next_msg.payload.status.power        = power_state;
                next_msg.payload.status.link         = link_state;
            end
            COORD_POWER_SYNC: begin
                load                    = is_coordinator;
                next_msg.msg_type       = MSG_POWER_ACK;
                next_msg.payload.power.pwr = consensus;
            end
            default: load = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coord_valid <= 1'b0;
            seq_q       <= '0;
        end else if (!coord_valid || coord_ready) begin
            coord_valid <= load;
            if (load) seq_q <= seq_q + 8'd1;
        end
    end

    // Held while the link back-pressures
    always_ff @(posedge clk) begin
        if ((!coord_valid || coord_ready) && load) coord_data <= next_msg;
    end

endmodule

/* hw/multi_module_coord.sv */
module multi_module_coord #(
    parameter int NUM_MODULES   = 4,
    parameter int MODULE_ID     = 0,
    parameter int COORD_TIMEOUT = 1000
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // Receive slots, one per die
    input  logic [NUM_MODULES-1:0]  coord_valid_in,
    input  coord_pkg::coord_msg_t   coord_data_in [NUM_MODULES],

    // Transmit with valid/ready
    output logic                    coord_valid,
    output coord_pkg::coord_msg_t   coord_data,
    input  logic                    coord_ready,

    // Local status
    input  coord_pkg::link_state_e  link_state,
    input  coord_pkg::power_state_e power_state,
    input  logic [7:0]              active_lanes,
    input  coord_pkg::power_state_e power_sync_req,

    output logic                    multi_module_active,
    output logic                    coordinator_role,
    output coord_pkg::coord_state_e coordination_phase,
    output logic                    power_sync_ack,
    output coord_pkg::power_state_e coordinated_power_state
);

    import coord_pkg::*;

    peer_rec_t              peers [NUM_MODULES];
    logic [NUM_MODULES-1:0] peer_pwr_req;
    power_state_e           peer_pwr_val [NUM_MODULES];
    logic                   pwr_pending;

    // Decode
    coord_msg_decode #(.NUM_MODULES(NUM_MODULES), .MODULE_ID(MODULE_ID)) u_decode (
        .clk, .rst_n, .coord_valid_in, .coord_data_in,
        .peers, .peer_pwr_req, .peer_pwr_val
    );

    // Execute
    coord_sequencer #(
        .NUM_MODULES(NUM_MODULES), .MODULE_ID(MODULE_ID), .COORD_TIMEOUT(COORD_TIMEOUT)
    ) u_sequencer (
        .clk, .rst_n, .peers, .active_lanes, .pwr_pending,
        .state(coordination_phase), .is_coordinator(coordinator_role)
    );

    power_consensus #(.NUM_MODULES(NUM_MODULES), .MODULE_ID(MODULE_ID)) u_consensus (
        .clk, .rst_n, .state(coordination_phase), .peers, .peer_pwr_req, .peer_pwr_val,
        .power_state, .power_sync_req, .pwr_pending, .coordinated_power_state
    );

    // Result
    coord_msg_encode #(.MODULE_ID(MODULE_ID)) u_encode (
        .clk, .rst_n, .state(coordination_phase), .is_coordinator(coordinator_role),
        .active_lanes, .power_state, .link_state, .consensus(coordinated_power_state),
        .coord_ready, .coord_valid, .coord_data
    );

    assign multi_module_active = (coordination_phase == COORD_ACTIVE);
    assign power_sync_ack      = (coordination_phase == COORD_ACTIVE) && !pwr_pending;

endmodule

/* dv/coord_props.sv */
module coord_props (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    coord_valid,
    input logic                    coord_ready,
    input coord_pkg::coord_msg_t   coord_data,
    input logic                    power_sync_ack,
    input coord_pkg::coord_state_e coordination_phase,
    input logic                    coordinator_role
);

    import coord_pkg::*;

    // Assertion failures so far
    int fail_count = 0;

    // Outgoing word frozen under back-pressure
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        coord_valid && !coord_ready |=> coord_valid && $stable(coord_data))
        else begin
            fail_count++;
            $error("coord_data or coord_valid moved while the transfer was stalled");
        end

    // Ack means ACTIVE with no power sync starting on the next cycle
    ack_in_active: assert property (@(posedge clk) disable iff (!rst_n)
        power_sync_ack |=> $past(coordination_phase) == COORD_ACTIVE &&
            coordination_phase == COORD_ACTIVE)
        else begin
            fail_count++;
            $error("power_sync_ack high outside ACTIVE or just before a power sync");
        end

    quiet_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
        coordination_phase == COORD_RESET |-> !coord_valid)
        else begin
            fail_count++;
            $error("coord_valid high in RESET");
        end

    // Role is only decided when negotiation starts
    role_on_election: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(coordinator_role) |-> coordination_phase == COORD_NEGOTIATION &&
            $past(coordination_phase) == COORD_DISCOVERY)
        else begin
            fail_count++;
            $error("coordinator_role changed outside entry to NEGOTIATION");
        end

endmodule

/* dv/tb_multi_module_coord.sv */
module tb_multi_module_coord;

    import coord_pkg::*;

    localparam int NUM_MODULES   = 4;
    localparam int MODULE_ID     = 0;
    localparam int COORD_TIMEOUT = 32;

    // One stimulus step and the state expected once its wait has passed
    typedef struct packed {
        logic         rst_first;
        logic         send;
        logic [1:0]   slot;
        msg_type_e    mtype;
        logic [7:0]   lanes;
        link_state_e  link;
        power_state_e pwr;
        logic [7:0]   local_lanes;
        power_state_e local_req;
        logic [7:0]   wait_cycles;
        coord_state_e exp_state;
        logic         exp_role;
        power_state_e exp_cpwr;
    } row_t;

    localparam int num_rows = 14;

    // ========================================================================
    // Test table
    // ========================================================================

    localparam row_t rows [num_rows] = '{
        // No peers, timeout into ERROR then back to DISCOVERY
        '{1'b1, 1'b0, 2'd0, MSG_DISCOVERY, 8'd0, LINK_RESET, PWR_L0, 8'd8, PWR_L0, 8'd34,
          COORD_ERROR, 1'b0, PWR_L0},
        '{1'b0, 1'b0, 2'd0, MSG_DISCOVERY, 8'd0, LINK_RESET, PWR_L0, 8'd8, PWR_L0, 8'd33,
          COORD_DISCOVERY, 1'b0, PWR_L0},
        // Peer 2 has more lanes and wins the election
        '{1'b0, 1'b1, 2'd2, MSG_DISCOVERY, 8'd16, LINK_RESET, PWR_L0, 8'd8, PWR_L0, 8'd3,
          COORD_NEGOTIATION, 1'b0, PWR_L0},
        '{1'b0, 1'b1, 2'd2, MSG_STATUS, 8'd16, LINK_ACTIVE, PWR_L0, 8'd8, PWR_L0, 8'd3,
          COORD_ACTIVE, 1'b0, PWR_L0},
        // Long ACTIVE stretch for the transmit monitor
        '{1'b0, 1'b0, 2'd0, MSG_DISCOVERY, 8'd0, LINK_RESET, PWR_L0, 8'd8, PWR_L0, 8'd40,
          COORD_ACTIVE, 1'b0, PWR_L0},
        // Equal lanes, lower ID wins
        '{1'b1, 1'b1, 2'd2, MSG_DISCOVERY, 8'd16, LINK_RESET, PWR_L0, 8'd16, PWR_L0, 8'd3,
          COORD_NEGOTIATION, 1'b1, PWR_L0},
        '{1'b0, 1'b1, 2'd1, MSG_DISCOVERY, 8'd4, LINK_RESET, PWR_L0, 8'd16, PWR_L0, 8'd3,
          COORD_NEGOTIATION, 1'b1, PWR_L0},
        '{1'b0, 1'b1, 2'd3, MSG_DISCOVERY, 8'd4, LINK_RESET, PWR_L0, 8'd16, PWR_L0, 8'd3,
          COORD_NEGOTIATION, 1'b1, PWR_L0},
        '{1'b0, 1'b1, 2'd1, MSG_STATUS, 8'd4, LINK_ACTIVE, PWR_L0, 8'd16, PWR_L0, 8'd3,
          COORD_NEGOTIATION, 1'b1, PWR_L0},
        '{1'b0, 1'b1, 2'd2, MSG_STATUS, 8'd16, LINK_ACTIVE, PWR_L0, 8'd16, PWR_L0, 8'd3,
          COORD_NEGOTIATION, 1'b1, PWR_L0},
        '{1'b0, 1'b1, 2'd3, MSG_STATUS, 8'd4, LINK_ACTIVE, PWR_L0, 8'd16, PWR_L0, 8'd3,
          COORD_ACTIVE, 1'b1, PWR_L0},
        // Votes L1, L2, L0, L0 so no level above L0 reaches half
        '{1'b0, 1'b1, 2'd1, MSG_POWER_REQ, 8'd0, LINK_RESET, PWR_L2, 8'd16, PWR_L1, 8'd4,
          COORD_ACTIVE, 1'b1, PWR_L0},
        '{1'b0, 1'b1, 2'd2, MSG_POWER_REQ, 8'd0, LINK_RESET, PWR_L2, 8'd16, PWR_L1, 8'd3,
          COORD_POWER_SYNC, 1'b1, PWR_L0},
        // Votes L1, L2, L2, L0 and L2 holds half
        '{1'b0, 1'b0, 2'd0, MSG_DISCOVERY, 8'd0, LINK_RESET, PWR_L0, 8'd16, PWR_L1, 8'd3,
          COORD_ACTIVE, 1'b1, PWR_L2}
    };

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic [NUM_MODULES-1:0] coord_valid_in;
    coord_msg_t             coord_data_in [NUM_MODULES];
    logic                   coord_valid;
    coord_msg_t             coord_data;
    logic                   coord_ready;
    link_state_e            link_state;
    power_state_e           power_state;
    logic [7:0]             active_lanes;
    power_state_e           power_sync_req;
    logic                   multi_module_active;
    logic                   coordinator_role;
    coord_state_e           coordination_phase;
    logic                   power_sync_ack;
    power_state_e           coordinated_power_state;

    logic [31:0] lfsr = 32'hc7fd;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          status_seen = 0;
    logic        have_prev = 1'b0;
    logic [7:0]  prev_seq;
    logic        held = 1'b0;
    coord_msg_t  held_data;

    multi_module_coord #(
        .NUM_MODULES(NUM_MODULES), .MODULE_ID(MODULE_ID), .COORD_TIMEOUT(COORD_TIMEOUT)
    ) UUT (
        .clk, .rst_n, .coord_valid_in, .coord_data_in,
        .coord_valid, .coord_data, .coord_ready,
        .link_state, .power_state, .active_lanes, .power_sync_req,
        .multi_module_active, .coordinator_role, .coordination_phase,
        .power_sync_ack, .coordinated_power_state
    );

    bind multi_module_coord coord_props u_props (
        .clk(clk), .rst_n(rst_n), .coord_valid(coord_valid), .coord_ready(coord_ready),
        .coord_data(coord_data), .power_sync_ack(power_sync_ack),
        .coordination_phase(coordination_phase), .coordinator_role(coordinator_role)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic check(input bit ok, input string what);
        assert (ok) else begin
            errors++;
            $display("ERROR %0t: %s", $time, what);
        end
    endtask

    // Random back-pressure, one LFSR step per cycle
    always @(posedge clk) begin
        #1;
        lfsr = lfsr_step(lfsr);
        coord_ready = lfsr[0];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // ========================================================================
    // Transmit monitor, sampled mid-cycle
    // ========================================================================

    always @(negedge clk) begin
        if (!rst_n) begin
            have_prev = 1'b0;
            held      = 1'b0;
        end else begin
            if (held) begin
                check(coord_valid && coord_data == held_data,
                      "held message changed before it was accepted");
            end
            if (coord_valid && coord_ready) begin
                check(coord_data.source_id == 4'(MODULE_ID),
                      $sformatf("source id %0d, expected %0d",
                                coord_data.source_id, MODULE_ID));
                if (have_prev) begin
                    check(coord_data.seq_num == prev_seq + 8'd1,
                          $sformatf("sequence %0d after %0d", coord_data.seq_num, prev_seq));
                end
                if (coord_data.msg_type == MSG_STATUS) begin
                    status_seen++;
                    check(coord_data.payload.status.active_lanes == active_lanes &&
                          coord_data.payload.status.power == power_state &&
                          coord_data.payload.status.link == link_state,
                          $sformatf("STATUS payload %h does not match local state",
                                    coord_data.payload));
                end
                have_prev = 1'b1;
                prev_seq  = coord_data.seq_num;
            end
            held      = coord_valid && !coord_ready;
            held_data = coord_data;
        end
    end

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        check(!coord_valid && !multi_module_active && !power_sync_ack && !coordinator_role &&
              coordination_phase == COORD_RESET, "outputs not at reset values");
        rst_n = 1'b1;
    endtask

    task automatic run_row(input int idx);
        row_t       r;
        coord_msg_t msg;
        int         errs_before;
        bit         exp_active;
        r           = rows[idx];
        errs_before = errors;
        if (r.rst_first) apply_reset();
        active_lanes   = r.local_lanes;
        power_sync_req = r.local_req;
        if (r.send) begin
            msg           = '0;
            msg.msg_type  = r.mtype;
            msg.source_id = 4'(r.slot);
            if (r.mtype == MSG_POWER_REQ) begin
                msg.payload.power.pwr = r.pwr;
            end else begin
                msg.payload.status.active_lanes = r.lanes;
                msg.payload.status.power        = r.pwr;
                msg.payload.status.link         = r.link;
            end
            coord_data_in[r.slot]  = msg;
            coord_valid_in[r.slot] = 1'b1;
        end
        @(posedge clk);
        #1;
        coord_valid_in = '0;
        repeat (r.wait_cycles - 1) begin
            @(posedge clk);
            #1;
        end
        // Every row ends with no vote pending, so ack follows ACTIVE
        exp_active = (r.exp_state == COORD_ACTIVE);
        check(coordination_phase == r.exp_state,
              $sformatf("row %0d phase %s, expected %s",
                        idx, coordination_phase.name(), r.exp_state.name()));
        check(coordinator_role == r.exp_role,
              $sformatf("row %0d role %0b, expected %0b", idx, coordinator_role, r.exp_role));
        check(coordinated_power_state == r.exp_cpwr,
              $sformatf("row %0d power %s, expected %s",
                        idx, coordinated_power_state.name(), r.exp_cpwr.name()));
        check(multi_module_active == exp_active && power_sync_ack == exp_active,
              $sformatf("row %0d active %0b ack %0b, expected %0b",
                        idx, multi_module_active, power_sync_ack, exp_active));
        if (errors == errs_before) begin
            tests_passed++;
            $display("row %0d %s: pass", idx, r.exp_state.name());
        end else begin
            tests_failed++;
            $display("row %0d %s: FAIL", idx, r.exp_state.name());
        end
    endtask

    initial begin
        int total_wait;
        rst_n          = 1'b0;
        coord_valid_in = '0;
        coord_data_in  = '{default: '0};
        coord_ready    = 1'b0;
        link_state     = LINK_ACTIVE;
        power_state    = PWR_L0;
        active_lanes   = 8'd8;
        power_sync_req = PWR_L0;
        total_wait     = 0;
        for (int i = 0; i < num_rows; i++) begin
            total_wait += int'(rows[i].wait_cycles);
        end
        // Margin covers the reset periods
        cycle_limit = total_wait + 4 * COORD_TIMEOUT + 64;

        @(posedge clk);
        #1;
        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end

        assert (status_seen > 0) else begin
            errors++;
            $display("No STATUS message was accepted while the link was active");
        end
        assert (UUT.u_props.fail_count == 0) else begin
            errors++;
            $display("%0d property checks on the DUT ports failed", UUT.u_props.fail_count);
        end
        $display("%0d tests: %0d passed, %0d failed, %0d check errors",
                 num_rows, tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* list.f */
hw/coord_pkg.sv
hw/coord_msg_decode.sv
hw/coord_sequencer.sv
hw/power_consensus.sv
hw/coord_msg_encode.sv
hw/multi_module_coord.sv
dv/coord_props.sv
dv/tb_multi_module_coord.sv

/* Makefile */
TOP := tb_multi_module_coord

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --assert --timing --top-module $(TOP) -Mdir obj_dir -f list.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
